/* source/periph_pkg.sv */
`default_nettype none

package periph_pkg;

	// APB port widths.
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// Address map. Bits 15 to 12 pick the slave, so each window is 4 KB.
	localparam int WIN_LSB   = 12;
	localparam int SLV_IDX_W = ADDR_W - WIN_LSB;
	localparam int OFS_W     = WIN_LSB;

	localparam int SLV_DEVTBL  = 0;
	localparam int SLV_GPIO    = 1;
	localparam int SLV_INTCTRL = 2;
	localparam int SLV_COUNT   = 3;

	// Device table contents, indexed by slave.
	localparam logic [DATA_W-1:0] DEV_ID [SLV_COUNT] = '{32'd7, 32'd6, 32'd3};
	localparam logic [DATA_W-1:0] DEV_MAPSZ [SLV_COUNT] = '{32'd4096, 32'd4096, 32'd4096};
	localparam logic DEV_USEINTR [SLV_COUNT] = '{1'b0, 1'b1, 1'b0};

	// Device table layout.
	localparam int DT_STRIDE = 8;
	localparam logic [OFS_W-1:0] DT_ID_OFS    = 12'h000;
	localparam logic [OFS_W-1:0] DT_MAPSZ_OFS = 12'h004;
	localparam logic [OFS_W-1:0] RST_CTRL_OFS = 12'h100;

	// GPIO registers.
	localparam int GPIO_COUNT = 16;
	localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 12'h000;
	localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 12'h004;
	localparam logic [OFS_W-1:0] GPIO_IEN_OFS = 12'h008;

	// Interrupt controller registers and sources.
	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_GPIO  = 0;
	localparam int INT_SRC_EXT   = 1;
	localparam logic [OFS_W-1:0] INT_PEND_OFS = 12'h000;
	localparam logic [OFS_W-1:0] INT_EN_OFS   = 12'h004;

	// Reset hold counter.
	localparam int RST_CNT_W = 5;
	localparam logic [RST_CNT_W-1:0] RST_HOLD_CYCLES = 5'd31;

	typedef enum logic [1:0] {
		CMD_NONE     = 2'd0,
		CMD_POWEROFF = 2'd1,
		CMD_WARM     = 2'd2,
		CMD_COLD     = 2'd3
	} rst_cmd_e;

	typedef enum logic [1:0] {
		ST_HOLD,
		ST_COUNT,
		ST_RUN,
		ST_OFF
	} rst_state_e;

endpackage

`default_nettype wire

/* source/rst_seq.sv */
`default_nettype none

module rst_seq (
	input  logic                  clk100mhz_i,
	input  logic                  rst_p,
	input  periph_pkg::rst_cmd_e  rst_cmd_i,
	output logic                  sys_rst_o
);
	import periph_pkg::*;

	rst_state_e           state_q;
	logic [RST_CNT_W-1:0] cnt_q;
	logic                 sys_rst_q;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			state_q   <= ST_HOLD;
			cnt_q     <= RST_HOLD_CYCLES;
			sys_rst_q <= 1'b1;
		end else begin
			case (state_q)
				ST_HOLD: begin
					// First edge with rst_p low starts the hold count.
					state_q <= ST_COUNT;
					cnt_q   <= RST_HOLD_CYCLES;
				end
				ST_COUNT: begin
					cnt_q <= cnt_q - 1'b1;
					// Counter reaches zero on the edge that releases the reset.
					if (cnt_q == RST_CNT_W'(1)) begin
						state_q   <= ST_RUN;
						sys_rst_q <= 1'b0;
					end
				end
				ST_RUN: begin
					case (rst_cmd_i)
						// No config device here, so cold acts as warm.
						CMD_WARM, CMD_COLD: begin
							state_q   <= ST_COUNT;
							cnt_q     <= RST_HOLD_CYCLES;
							sys_rst_q <= 1'b1;
						end
						CMD_POWEROFF: begin
							state_q   <= ST_OFF;
							sys_rst_q <= 1'b1;
						end
						default: begin
							state_q <= ST_RUN;
						end
					endcase
				end
				ST_OFF: begin
					// Only rst_p gets out of here.
					sys_rst_q <= 1'b1;
				end
				default: begin
					state_q <= ST_HOLD;
				end
			endcase
		end
	end

	assign sys_rst_o = sys_rst_q;

endmodule

`default_nettype wire

/* source/apb_decoder.sv */
`default_nettype none

module apb_decoder (
	input  logic                                                  clk100mhz_i,
	input  logic [periph_pkg::ADDR_W-1:0]                         paddr_i,
	input  logic                                                  psel_i,
	input  logic                                                  penable_i,
	input  logic                                                  pwrite_i,
	output logic [periph_pkg::SLV_COUNT-1:0]                      sel_o,
	output logic                                                  wr_en_o,
	input  logic [periph_pkg::SLV_COUNT-1:0][periph_pkg::DATA_W-1:0] rdata_i,
	output logic [periph_pkg::DATA_W-1:0]                         prdata_o,
	output logic                                                  pready_o
);
	import periph_pkg::*;

	logic [SLV_IDX_W-1:0] win;
	// Window of the current transfer, captured in its setup cycle.
	logic [SLV_IDX_W-1:0] win_q;

	assign win = paddr_i[ADDR_W-1:WIN_LSB];

	// One-hot select for mapped windows.
	always_comb begin
		sel_o = '0;
		for (int i = 0; i < SLV_COUNT; i++) begin
			if (psel_i && (win == SLV_IDX_W'(i))) begin
				sel_o[i] = 1'b1;
			end
		end
	end

	assign wr_en_o = psel_i & penable_i & pwrite_i;

	// All slaves, the default one too, answer without wait states.
	assign pready_o = psel_i & penable_i;

	always_ff @(posedge clk100mhz_i) begin
		if (psel_i && !penable_i) begin
			win_q <= win;
		end
	end

	// Read mux. Unmapped windows fall through to the default slave,
	// which reads zero and ignores writes.
	always_comb begin
		prdata_o = '0;
		for (int i = 0; i < SLV_COUNT; i++) begin
			if (win_q == SLV_IDX_W'(i)) begin
				prdata_o = rdata_i[i];
			end
		end
	end

endmodule

`default_nettype wire

/* source/devtbl.sv */
`default_nettype none

module devtbl (
	input  logic                          clk100mhz_i,
	input  logic                          sys_rst_i,
	input  logic                          sel_i,
	input  logic                          wr_en_i,
	input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
	input  logic [periph_pkg::DATA_W-1:0] pwdata_i,
	output logic [periph_pkg::DATA_W-1:0] rdata_o,
	output periph_pkg::rst_cmd_e          rst_cmd_o
);
	import periph_pkg::*;

	logic [OFS_W-1:0] ofs;
	logic             wr;
	rst_cmd_e         cmd_q;

	assign ofs = paddr_i[OFS_W-1:0];
	assign wr  = sel_i & wr_en_i;

	// Reset command register. It clears itself once rst_seq
	// pulls the subsystem into reset.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			cmd_q <= CMD_NONE;
		end else if (wr && (ofs == RST_CTRL_OFS)) begin
			cmd_q <= rst_cmd_e'(pwdata_i[1:0]);
		end
	end

	assign rst_cmd_o = cmd_q;

	// Two words per entry: the id, then the map size with the
	// uses-interrupt flag in bit 0.
	always_comb begin
		rdata_o = '0;
		for (int i = 0; i < SLV_COUNT; i++) begin
			if (ofs == (DT_ID_OFS + OFS_W'(DT_STRIDE * i))) begin
				rdata_o = DEV_ID[i];
			end
			if (ofs == (DT_MAPSZ_OFS + OFS_W'(DT_STRIDE * i))) begin
				rdata_o = DEV_MAPSZ[i] | DATA_W'(DEV_USEINTR[i]);
			end
		end
		if (ofs == RST_CTRL_OFS) begin
			rdata_o = DATA_W'(cmd_q);
		end
	end

endmodule

`default_nettype wire

/* source/gpio.sv */
`default_nettype none

module gpio (
	input  logic                              clk100mhz_i,
	input  logic                              sys_rst_i,
	input  logic                              sel_i,
	input  logic                              wr_en_i,
	input  logic [periph_pkg::ADDR_W-1:0]     paddr_i,
	input  logic [periph_pkg::DATA_W-1:0]     pwdata_i,
	output logic [periph_pkg::DATA_W-1:0]     rdata_o,
	input  logic [periph_pkg::GPIO_COUNT-1:0] gpio_i,
	output logic [periph_pkg::GPIO_COUNT-1:0] gpio_o,
	output logic                              chg_irq_o
);
	import periph_pkg::*;

	logic [OFS_W-1:0]      ofs;
	logic                  wr;
	logic [GPIO_COUNT-1:0] sync_q;
	logic [GPIO_COUNT-1:0] in_q;
	logic [GPIO_COUNT-1:0] out_q;
	logic [GPIO_COUNT-1:0] ien_q;
	logic                  chg_q;

	assign ofs = paddr_i[OFS_W-1:0];
	assign wr  = sel_i & wr_en_i;

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			sync_q <= '0;
			in_q   <= '0;
			out_q  <= '0;
			ien_q  <= '0;
			chg_q  <= 1'b0;
		end else begin
			// Two-flop synchronizer.
			sync_q <= gpio_i;
			in_q   <= sync_q;
			// Flag any enabled bit about to change in GPIO_IN.
			chg_q  <= |((sync_q ^ in_q) & ien_q);
			if (wr && (ofs == GPIO_OUT_OFS)) begin
				out_q <= pwdata_i[GPIO_COUNT-1:0];
			end
			if (wr && (ofs == GPIO_IEN_OFS)) begin
				ien_q <= pwdata_i[GPIO_COUNT-1:0];
			end
		end
	end

	assign gpio_o    = out_q;
	assign chg_irq_o = chg_q;

	always_comb begin
		case (ofs)
			GPIO_IN_OFS:  rdata_o = DATA_W'(in_q);
			GPIO_OUT_OFS: rdata_o = DATA_W'(out_q);
			GPIO_IEN_OFS: rdata_o = DATA_W'(ien_q);
			default:      rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/intctrl.sv */
`default_nettype none

module intctrl (
	input  logic                                 clk100mhz_i,
	input  logic                                 sys_rst_i,
	input  logic                                 sel_i,
	input  logic                                 wr_en_i,
	input  logic [periph_pkg::ADDR_W-1:0]        paddr_i,
	input  logic [periph_pkg::DATA_W-1:0]        pwdata_i,
	output logic [periph_pkg::DATA_W-1:0]        rdata_o,
	input  logic [periph_pkg::INT_SRC_COUNT-1:0] src_i,
	output logic                                 irq_o
);
	import periph_pkg::*;

	logic [OFS_W-1:0]         ofs;
	logic                     wr;
	logic [INT_SRC_COUNT-1:0] clr;
	logic [INT_SRC_COUNT-1:0] pend_q;
	logic [INT_SRC_COUNT-1:0] en_q;

	assign ofs = paddr_i[OFS_W-1:0];
	assign wr  = sel_i & wr_en_i;

	// Write-1-to-clear mask for INT_PEND.
	assign clr = (wr && (ofs == INT_PEND_OFS)) ? pwdata_i[INT_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			pend_q <= '0;
			en_q   <= '0;
		end else begin
			// Sticky bits. A source still high wins over the clear.
			pend_q <= (pend_q & ~clr) | src_i;
			if (wr && (ofs == INT_EN_OFS)) begin
				en_q <= pwdata_i[INT_SRC_COUNT-1:0];
			end
		end
	end

	// Processor interrupt line
	assign irq_o = |(pend_q & en_q);

	always_comb begin
		case (ofs)
			INT_PEND_OFS: rdata_o = DATA_W'(pend_q);
			INT_EN_OFS:   rdata_o = DATA_W'(en_q);
			default:      rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/periph_top.sv */
`default_nettype none

module periph_top (
	input  logic                              clk100mhz_i,
	input  logic                              rst_p,
	input  logic [periph_pkg::ADDR_W-1:0]     paddr_i,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [periph_pkg::DATA_W-1:0]     pwdata_i,
	output logic [periph_pkg::DATA_W-1:0]     prdata_o,
	output logic                              pready_o,
	input  logic [periph_pkg::GPIO_COUNT-1:0] gpio_i,
	output logic [periph_pkg::GPIO_COUNT-1:0] gpio_o,
	input  logic                              ext_irq_i,
	output logic                              irq_o,
	output logic                              sys_rst_o
);
	import periph_pkg::*;

	logic [SLV_COUNT-1:0]             sel;
	logic                             wr_en;
	logic [SLV_COUNT-1:0][DATA_W-1:0] rdata;
	rst_cmd_e                         rst_cmd;
	logic                             sys_rst;
	logic                             gpio_chg;
	logic [INT_SRC_COUNT-1:0]         int_src;

	assign int_src[INT_SRC_GPIO] = gpio_chg;
	assign int_src[INT_SRC_EXT]  = ext_irq_i;
	assign sys_rst_o             = sys_rst;

	rst_seq u_rst_seq (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.rst_cmd_i   (rst_cmd),
		.sys_rst_o   (sys_rst)
	);

	apb_decoder u_apb_decoder (
		.clk100mhz_i (clk100mhz_i),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.sel_o       (sel),
		.wr_en_o     (wr_en),
		.rdata_i     (rdata),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o)
	);

	devtbl u_devtbl (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.sel_i       (sel[SLV_DEVTBL]),
		.wr_en_i     (wr_en),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.rdata_o     (rdata[SLV_DEVTBL]),
		.rst_cmd_o   (rst_cmd)
	);

	gpio u_gpio (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.sel_i       (sel[SLV_GPIO]),
		.wr_en_i     (wr_en),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.rdata_o     (rdata[SLV_GPIO]),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.chg_irq_o   (gpio_chg)
	);

	intctrl u_intctrl (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.sel_i       (sel[SLV_INTCTRL]),
		.wr_en_i     (wr_en),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.rdata_o     (rdata[SLV_INTCTRL]),
		.src_i       (int_src),
		.irq_o       (irq_o)
	);

endmodule

`default_nettype wire

/* tests/periph_props.sv */
`default_nettype none

module periph_props (
	input logic                              clk100mhz_i,
	input logic                              rst_p,
	input logic [periph_pkg::ADDR_W-1:0]     paddr_i,
	input logic                              psel_i,
	input logic                              penable_i,
	input logic                              pwrite_i,
	input logic [periph_pkg::DATA_W-1:0]     pwdata_i,
	input logic                              pready_i,
	input logic [periph_pkg::GPIO_COUNT-1:0] gpio_out_i,
	input logic                              irq_i,
	input logic                              sys_rst_i
);
	timeunit 1ns;
	timeprecision 100ps;
	import periph_pkg::*;

	logic off_q;

	// Set by a power-off write that devtbl accepts, cleared by rst_p.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			off_q <= 1'b0;
		end else if (psel_i && penable_i && pwrite_i && !sys_rst_i
				&& paddr_i == ADDR_W'(RST_CTRL_OFS) && pwdata_i[1:0] == CMD_POWEROFF) begin
			off_q <= 1'b1;
		end
	end

	a_pready: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		psel_i && penable_i |-> pready_i)
		else $error("pready_o low in an APB access cycle");

	// Outputs are registered, so they clear one edge after the reset rises.
	a_rst_outputs: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		sys_rst_i && $past(sys_rst_i) |-> gpio_out_i == '0 && !irq_i)
		else $error("gpio_o or irq_o active during subsystem reset");

	a_poweroff: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		off_q |=> sys_rst_i)
		else $error("sys_rst_o fell after power-off without rst_p");

endmodule

bind periph_top periph_props props (
	.clk100mhz_i (clk100mhz_i),
	.rst_p       (rst_p),
	.paddr_i     (paddr_i),
	.psel_i      (psel_i),
	.penable_i   (penable_i),
	.pwrite_i    (pwrite_i),
	.pwdata_i    (pwdata_i),
	.pready_i    (pready_o),
	.gpio_out_i  (gpio_o),
	.irq_i       (irq_o),
	.sys_rst_i   (sys_rst_o)
);

`default_nettype wire

/* tests/periph_tb.sv */
`default_nettype none

module periph_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HOLD_EDGES = 31;
	// Rough cycle budgets of the five tests. The watchdog allows twice that.
	localparam int TEST_CYCLES = 60 + 40 + 80 + 60 + 200;
	localparam int WATCHDOG_NS = TEST_CYCLES * 10 * 2 + 1000;

	logic        clk;
	logic        rst_p;
	logic [15:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic [15:0] gpio_in;
	logic [15:0] gpio_out;
	logic        ext_irq;
	logic        irq;
	logic        sys_rst;
	int          checks;
	int          errors;
	int          seed;

	periph_top DUT (
		.clk100mhz_i (clk),
		.rst_p       (rst_p),
		.paddr_i     (paddr),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.pwdata_i    (pwdata),
		.prdata_o    (prdata),
		.pready_o    (pready),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_out),
		.ext_irq_i   (ext_irq),
		.irq_o       (irq),
		.sys_rst_o   (sys_rst)
	);

	always #5 clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("FAILED %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		$display("%-16s done, %0d errors", name, errors - err_before);
	endtask

	// One APB transfer that starts and ends 1 ns after a rising edge.
	task automatic apb_xfer(input logic [15:0] addr, input logic write,
			input logic [31:0] wdata, output logic [31:0] rdata, output int cycles);
		int waits;
		waits = 0;
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		cycles = 1;
		@(posedge clk);
		#1;
		penable = 1'b1;
		cycles = 2;
		#1;
		while (!pready && waits < 8) begin
			@(posedge clk);
			#2;
			waits++;
			cycles++;
		end
		if (!pready) begin
			$display("APB transfer to %h got no pready_o", addr);
			errors++;
		end
		rdata = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic count_release(output int edges);
		edges = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (sys_rst && edges < 64);
		if (sys_rst) begin
			$display("sys_rst_o did not fall within 64 edges");
			errors++;
		end
	endtask

	task automatic reset_and_release();
		int edges;
		rst_p = 1'b1;
		repeat (16) begin
			@(posedge clk);
			#1;
			check_val("sys_rst_o", 32'd1, 32'(sys_rst));
		end
		rst_p = 1'b0;
		count_release(edges);
		// The edge that first sees rst_p low plus the hold count.
		check_val("sys_rst_o release edge", 32'(1 + HOLD_EDGES), edges);
	endtask

	task automatic read_dev_table();
		logic [31:0] id_exp [3];
		logic [31:0] flag_exp [3];
		logic [31:0] data;
		int          cycles;
		id_exp = '{32'd7, 32'd6, 32'd3};
		flag_exp = '{32'd0, 32'd1, 32'd0};
		for (int i = 0; i < 3; i++) begin
			apb_xfer(16'(8 * i), 1'b0, 32'd0, data, cycles);
			check_val("prdata_o id", id_exp[i], data);
			apb_xfer(16'(8 * i + 4), 1'b0, 32'd0, data, cycles);
			check_val("prdata_o map size", 32'd4096 | flag_exp[i], data);
		end
		// Window 0x3 only has the default slave.
		apb_xfer(16'h3010, 1'b1, 32'hdead_beef, data, cycles);
		check_val("write cycles", 32'd2, cycles);
		apb_xfer(16'h3010, 1'b0, 32'd0, data, cycles);
		check_val("prdata_o", 32'd0, data);
		check_val("read cycles", 32'd2, cycles);
	endtask

	task automatic drive_gpio();
		logic [31:0] data;
		int          cycles;
		apb_xfer(16'h1004, 1'b1, 32'h0000_a5c3, data, cycles);
		check_val("gpio_o", 32'h0000_a5c3, 32'(gpio_out));
		for (int k = 0; k < 8; k++) begin
			gpio_in = 16'($random(seed));
			// First synchronizer edge here, the second one ends the read's setup cycle.
			@(posedge clk);
			#1;
			apb_xfer(16'h1000, 1'b0, 32'd0, data, cycles);
			check_val("prdata_o gpio in", 32'(gpio_in), data);
		end
	endtask

	task automatic raise_interrupts();
		logic [31:0] data;
		int          cycles;
		apb_xfer(16'h1008, 1'b1, 32'h0000_ffff, data, cycles);
		gpio_in = gpio_in ^ 16'h0001;
		// Synchronizer, change flag, then the pending bit.
		repeat (4) @(posedge clk);
		#1;
		apb_xfer(16'h2000, 1'b0, 32'd0, data, cycles);
		check_val("INT_PEND", 32'd1, data);
		check_val("irq_o", 32'd0, 32'(irq));
		apb_xfer(16'h2004, 1'b1, 32'd1, data, cycles);
		check_val("irq_o", 32'd1, 32'(irq));
		apb_xfer(16'h2000, 1'b1, 32'd1, data, cycles);
		check_val("irq_o", 32'd0, 32'(irq));
		ext_irq = 1'b1;
		@(posedge clk);
		#1;
		ext_irq = 1'b0;
		apb_xfer(16'h2000, 1'b0, 32'd0, data, cycles);
		check_val("INT_PEND", 32'd2, data);
		check_val("irq_o", 32'd0, 32'(irq));
		apb_xfer(16'h2004, 1'b1, 32'd3, data, cycles);
		check_val("irq_o", 32'd1, 32'(irq));
		apb_xfer(16'h2000, 1'b1, 32'd2, data, cycles);
		check_val("irq_o", 32'd0, 32'(irq));
		apb_xfer(16'h2000, 1'b0, 32'd0, data, cycles);
		check_val("INT_PEND", 32'd0, data);
	endtask

	task automatic apply_sw_reset();
		logic [31:0] data;
		int          cycles;
		int          edges;
		check_val("gpio_o", 32'h0000_a5c3, 32'(gpio_out));
		// Warm reset command.
		apb_xfer(16'h0100, 1'b1, 32'd2, data, cycles);
		check_val("sys_rst_o", 32'd0, 32'(sys_rst));
		count_release(edges);
		check_val("sys_rst_o warm release edge", 32'(1 + HOLD_EDGES), edges);
		check_val("gpio_o", 32'd0, 32'(gpio_out));
		apb_xfer(16'h0100, 1'b0, 32'd0, data, cycles);
		check_val("RST_CTRL", 32'd0, data);
		// Power-off is left only through rst_p.
		apb_xfer(16'h0100, 1'b1, 32'd1, data, cycles);
		repeat (50) begin
			@(posedge clk);
			#1;
			check_val("sys_rst_o", 32'd1, 32'(sys_rst));
		end
		reset_and_release();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int err0;
		seed = 32'h674d4758;
		checks = 0;
		errors = 0;
		clk = 1'b0;
		rst_p = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		gpio_in = '0;
		ext_irq = 1'b0;
		err0 = errors;
		reset_and_release();
		end_test("reset release", err0);
		err0 = errors;
		read_dev_table();
		end_test("device table", err0);
		err0 = errors;
		drive_gpio();
		end_test("gpio", err0);
		err0 = errors;
		raise_interrupts();
		end_test("interrupts", err0);
		err0 = errors;
		apply_sw_reset();
		end_test("software reset", err0);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/periph_pkg.sv
source/rst_seq.sv
source/apb_decoder.sv
source/devtbl.sv
source/gpio.sv
source/intctrl.sv
source/periph_top.sv
tests/periph_props.sv
tests/periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module periph_tb -Mdir "$BUILD" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD/Vperiph_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0
